/* dv/tb_clk_gen.sv */
// Testbench clock source
// Free running clock with a configurable period
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen #(
    parameter real PERIOD_NS = 10.0
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2.0) clk = ~clk;
    end

endmodule

`default_nettype wire

/* dv/tb_game_board.sv */
// Testbench for the board wrapper
// Directed tests for reset stretching, joystick mapping, 4-way filter,
// buttons, pause and layer controls and the direct video path.
// Inputs change on the falling clock edge
`timescale 1ns/1ps
`default_nettype none

module tb_game_board;

    import board_pkg::*;

    localparam int        BUTTONS        = 2;
    localparam int        ACTIVE_LOW     = 1;
    localparam int        COLORW         = 4;
    localparam int        GAME_RST_LEN   = 255;
    localparam int        START_BIT      = 6 + BUTTONS - 2;
    localparam int        COIN_BIT       = 7 + BUTTONS - 2;
    localparam int        PAUSE_BIT      = 8 + BUTTONS - 2;
    localparam logic      INV            = ACTIVE_LOW != 0;
    localparam game_joy_t INV_MASK       = {JOY_GAME_W{INV}};
    localparam int        TIMEOUT_CYCLES = 2000;   // Tests take about 700 cycles

    logic clk_sys;
    logic rst, rst_req, downloading, en_4way, rot_control;
    board_joy_t board_joystick1, board_joystick2, board_joystick3, board_joystick4;
    logic key_reset, key_pause, key_service, osd_pause;
    logic [GFX_LAYERS-1:0] key_gfx;
    logic [COLORW-1:0] game_r, game_g, game_b;
    logic LHBL, LVBL, hs, vs;
    logic game_rst, game_rst_n, game_service, game_pause;
    game_joy_t game_joystick1, game_joystick2, game_joystick3, game_joystick4;
    logic [PLAYERS-1:0] game_coin, game_start;
    logic [GFX_LAYERS-1:0] gfx_en;
    logic [7:0] video_r, video_g, video_b;
    logic video_hs, video_vs, video_de;

    board_joy_t board_word [PLAYERS];   // Words driven onto the four board inputs
    logic [GFX_LAYERS-1:0] gfx_expect;
    int seed = 91;
    int error_count = 0;
    int cycle_cnt = 0;

    tb_clk_gen #(.PERIOD_NS(10.0)) u_clk_gen (.clk(clk_sys));

    game_board u_dut (
        .clk_sys(clk_sys), .rst(rst), .rst_req(rst_req), .downloading(downloading),
        .en_4way(en_4way), .rot_control(rot_control),
        .board_joystick1(board_joystick1), .board_joystick2(board_joystick2),
        .board_joystick3(board_joystick3), .board_joystick4(board_joystick4),
        .key_reset(key_reset), .key_pause(key_pause), .key_service(key_service),
        .key_gfx(key_gfx), .osd_pause(osd_pause),
        .game_r(game_r), .game_g(game_g), .game_b(game_b),
        .LHBL(LHBL), .LVBL(LVBL), .hs(hs), .vs(vs),
        .game_rst(game_rst), .game_rst_n(game_rst_n),
        .game_joystick1(game_joystick1), .game_joystick2(game_joystick2),
        .game_joystick3(game_joystick3), .game_joystick4(game_joystick4),
        .game_coin(game_coin), .game_start(game_start), .game_service(game_service),
        .game_pause(game_pause), .gfx_en(gfx_en),
        .video_r(video_r), .video_g(video_g), .video_b(video_b),
        .video_hs(video_hs), .video_vs(video_vs), .video_de(video_de)
    );

    task automatic stop_with_failure(input string reason);
        $display("%s", reason);
        $display("Checks failed");
        $fatal(1, "Simulation stopped");
    endtask

    task automatic check_joy(input game_joy_t got, input game_joy_t exp, input string what);
        if (got !== exp) begin
            error_count++;
            stop_with_failure($sformatf("Error at %0t: %s got %h, expected %h",
                                        $time, what, got, exp));
        end
    endtask

    task automatic check_bits4(input logic [3:0] got, input logic [3:0] exp, input string what);
        if (got !== exp) begin
            error_count++;
            stop_with_failure($sformatf("Error at %0t: %s got %b, expected %b",
                                        $time, what, got, exp));
        end
    endtask

    task automatic check_byte(input logic [7:0] got, input logic [7:0] exp, input string what);
        if (got !== exp) begin
            error_count++;
            stop_with_failure($sformatf("Error at %0t: %s got %h, expected %h",
                                        $time, what, got, exp));
        end
    endtask

    task automatic check_bit(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            error_count++;
            stop_with_failure($sformatf("Error at %0t: %s got %b, expected %b",
                                        $time, what, got, exp));
        end
    endtask

    task automatic settle(input int cycles);
        repeat (cycles) @(negedge clk_sys);
    endtask

    task automatic drive_boards();
        board_joystick1 = board_word[0];
        board_joystick2 = board_word[1];
        board_joystick3 = board_word[2];
        board_joystick4 = board_word[3];
    endtask

    function automatic game_joy_t joy_out(input int p);
        case (p)
            0:       return game_joystick1;
            1:       return game_joystick2;
            2:       return game_joystick3;
            default: return game_joystick4;
        endcase
    endfunction

    // Reference for the joystick path, rotated for vertical games
    function automatic game_joy_t expected_joy(input board_joy_t w, input logic rot);
        game_joy_t e;
        e = w[JOY_GAME_W-1:0];
        if (rot) begin
            e[3] = w[0];    // Up from right
            e[2] = w[1];
            e[1] = w[3];
            e[0] = w[2];
        end
        return e ^ INV_MASK;
    endfunction

    // Top 8 bits of the colour repeated end to end
    function automatic logic [7:0] widen(input logic [COLORW-1:0] c);
        logic [8*COLORW-1:0] rep;
        rep = {8{c}};
        return rep[8*COLORW-1 -: 8];
    endfunction

    task automatic check_stretch(input string cause);
        int n;
        for (int i = 0; i < GAME_RST_LEN; i++) begin
            @(negedge clk_sys);
            check_bit(game_rst, 1'b1, {"game_rst held after ", cause});
            check_bit(game_rst_n, 1'b0, {"game_rst_n held after ", cause});
        end
        n = 0;
        while (game_rst !== 1'b0 && n < 2) begin
            settle(1);
            n++;
        end
        check_bit(game_rst, 1'b0, {"game_rst released after ", cause});
        check_bit(game_rst_n, 1'b0, "game_rst_n at game_rst release");
        settle(1);
        check_bit(game_rst_n, 1'b0, "game_rst_n one cycle after release");
        settle(1);
        check_bit(game_rst_n, 1'b1, "game_rst_n two cycles after release");
    endtask

    task automatic stretch_reset_causes();
        check_stretch("rst");
        rst_req = 1'b1;
        settle(1);
        rst_req = 1'b0;
        check_stretch("rst_req");
    endtask

    task automatic map_random_joysticks();
        logic [31:0] rnd;
        en_4way = 1'b0;
        for (int n = 0; n < 8; n++) begin
            for (int p = 0; p < PLAYERS; p++) begin
                rnd = $random(seed);
                board_word[p] = rnd[JOY_BOARD_W-1:0];
            end
            drive_boards();
            for (int r = 0; r < 2; r++) begin
                rot_control = r[0];
                settle(5);
                for (int p = 0; p < PLAYERS; p++) begin
                    check_joy(joy_out(p), expected_joy(board_word[p], r[0]),
                              $sformatf("player %0d word %0d rot %0d", p + 1, n, r));
                end
            end
        end
        rot_control = 1'b0;
    endtask

    task automatic apply_4way(input dir_t din, input dir_t dexp, input string what);
        game_joy_t exp_joy;
        exp_joy = '0;
        exp_joy[DIR_W-1:0] = dexp;
        exp_joy = exp_joy ^ INV_MASK;
        for (int p = 0; p < PLAYERS; p++) begin
            board_word[p] = '0;
            board_word[p][DIR_W-1:0] = din;
        end
        drive_boards();
        settle(5);
        for (int p = 0; p < PLAYERS; p++) begin
            check_joy(joy_out(p), exp_joy, $sformatf("4-way %s player %0d", what, p + 1));
        end
    endtask

    task automatic filter_diagonals();
        en_4way = 1'b1;
        apply_4way(4'b0001, 4'b0001, "right");
        apply_4way(4'b1001, 4'b0001, "right plus up");
        apply_4way(4'b1000, 4'b1000, "up");
        apply_4way(4'b0000, 4'b0000, "none");
        en_4way = 1'b0;
    endtask

    task automatic apply_buttons(input logic [3:0] coin, input logic [3:0] start,
                                 input logic service);
        for (int p = 0; p < PLAYERS; p++) begin
            board_word[p] = '0;
            board_word[p][COIN_BIT]  = coin[p];
            board_word[p][START_BIT] = start[p];
        end
        key_service = service;
        drive_boards();
        settle(5);
        check_bits4(game_coin, coin ^ {4{INV}}, "game_coin");
        check_bits4(game_start, start ^ {4{INV}}, "game_start");
        check_bit(game_service, service ^ INV, "game_service");
    endtask

    task automatic map_coin_start_service();
        apply_buttons(4'b0101, 4'b1010, 1'b1);
        apply_buttons(4'b1100, 4'b0011, 1'b0);
        apply_buttons(4'b0000, 4'b0000, 1'b0);
    endtask

    // Source 0 key_pause, 1 osd_pause, 2 player 1 pause button, 3 downloading
    task automatic pulse_pause_source(input int src, input logic exp, input string what);
        case (src)
            0: key_pause = 1'b1;
            1: osd_pause = 1'b1;
            2: board_word[0][PAUSE_BIT] = 1'b1;
            default: downloading = 1'b1;
        endcase
        drive_boards();
        settle(1);
        key_pause   = 1'b0;
        osd_pause   = 1'b0;
        downloading = 1'b0;
        board_word[0][PAUSE_BIT] = 1'b0;
        drive_boards();
        settle(3);
        check_bit(game_pause, exp, what);
    endtask

    task automatic pulse_gfx(input int layer);
        gfx_expect[layer] = ~gfx_expect[layer];
        key_gfx = '0;
        key_gfx[layer] = 1'b1;
        settle(1);
        key_gfx = '0;
        settle(2);
        check_bits4(gfx_en, gfx_expect, $sformatf("gfx_en after layer %0d key", layer));
    endtask

    task automatic toggle_controls();
        int n;
        check_bit(game_rst, 1'b0, "game_rst low before soft reset");
        key_reset = 1'b1;
        settle(1);
        key_reset = 1'b0;
        n = 0;
        while (game_rst !== 1'b1 && n < 3) begin
            settle(1);
            n++;
        end
        check_bit(game_rst, 1'b1, "game_rst after key_reset");
        pulse_pause_source(3, 1'b0, "game_pause cleared by downloading");
        pulse_pause_source(0, 1'b1, "game_pause after key_pause");
        pulse_pause_source(1, 1'b0, "game_pause after osd_pause");
        pulse_pause_source(2, 1'b1, "game_pause after joystick pause");
        pulse_pause_source(3, 1'b0, "game_pause cleared again by downloading");
        pulse_gfx(2);
        pulse_gfx(0);
    endtask

    task automatic expand_video();
        logic [31:0] rnd;
        logic [COLORW-1:0] r, g, b;
        for (int n = 0; n < 8; n++) begin
            rnd = $random(seed);
            r = rnd[0 +: COLORW];
            g = rnd[COLORW +: COLORW];
            b = rnd[2*COLORW +: COLORW];
            game_r = r;
            game_g = g;
            game_b = b;
            LHBL = n[0];
            LVBL = n[1];
            hs   = rnd[30];
            vs   = rnd[31];
            settle(2);
            check_byte(video_r, widen(r), "video_r");
            check_byte(video_g, widen(g), "video_g");
            check_byte(video_b, widen(b), "video_b");
            check_bit(video_de, n[0] & n[1], "video_de");
            check_bit(video_hs, rnd[30], "video_hs");
            check_bit(video_vs, rnd[31], "video_vs");
        end
    endtask

    always @(posedge clk_sys) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt == TIMEOUT_CYCLES) begin
            stop_with_failure("Timeout: the tests did not finish within the cycle limit");
        end
    end

    initial begin
        rst = 1'b1;
        rst_req = 1'b0;
        downloading = 1'b0;
        en_4way = 1'b0;
        rot_control = 1'b0;
        for (int p = 0; p < PLAYERS; p++) board_word[p] = '0;
        drive_boards();
        key_reset = 1'b0;
        key_pause = 1'b0;
        key_service = 1'b1;                     // Pressed while rst is high
        key_gfx = '0;
        osd_pause = 1'b0;
        game_r = '0;
        game_g = '0;
        game_b = '0;
        LHBL = 1'b0;
        LVBL = 1'b0;
        hs = 1'b0;
        vs = 1'b0;
        gfx_expect = '1;                        // All layers on out of reset
        repeat (4) @(posedge clk_sys);
        @(negedge clk_sys);
        check_bit(game_pause, 1'b0, "game_pause during rst");
        check_bits4(gfx_en, 4'hF, "gfx_en during rst");
        check_bit(game_service, INV, "game_service during rst");
        rst = 1'b0;
        key_service = 1'b0;
        stretch_reset_causes();
        map_random_joysticks();
        filter_diagonals();
        map_coin_start_service();
        toggle_controls();
        expand_video();
        if (error_count == 0) begin
            $display("All checks passed");
            $finish;
        end else begin
            stop_with_failure("Mismatches were found");
        end
    end

endmodule

`default_nettype wire

/* src/board_ctrl.sv */
// Board level controls
// Rising edges toggle pause and the GFX layer enables, and the
// keyboard reset key gives a one-cycle soft reset pulse
`timescale 1ns/1ps
`default_nettype none

module board_ctrl (
    input  logic                             clk_sys,
    input  logic                             rst,
    input  logic                             downloading,
    input  logic                             key_reset,
    input  logic                             key_pause,
    input  logic                             joy_pause,
    input  logic                             osd_pause,
    input  logic [board_pkg::GFX_LAYERS-1:0] key_gfx,
    output logic                             soft_rst,
    output logic                             game_pause,
    output logic [board_pkg::GFX_LAYERS-1:0] gfx_en
);

    import board_pkg::*;

    logic                  last_reset;
    logic                  last_pause;
    logic                  last_joypause;
    logic                  last_osdpause;
    logic [GFX_LAYERS-1:0] last_gfx;
    logic                  pause_edge;

    // Previous input levels for edge detection
    always_ff @(posedge clk_sys) begin
        last_reset    <= key_reset;
        last_pause    <= key_pause;
        last_joypause <= joy_pause;
        last_osdpause <= osd_pause;
        last_gfx      <= key_gfx;
    end

    assign pause_edge = (key_pause && !last_pause) || (joy_pause && !last_joypause)
                     || (osd_pause && !last_osdpause);

    always_ff @(posedge clk_sys) begin
        if (rst) begin
            soft_rst   <= 1'b0;
            game_pause <= 1'b0;
            gfx_en     <= '1;                    // All layers on
        end else begin
            soft_rst <= key_reset && !last_reset;
            if (downloading) begin
                game_pause <= 1'b0;
            end else if (pause_edge) begin
                game_pause <= !game_pause;
            end
            for (int i = 0; i < GFX_LAYERS; i++) begin
                if (key_gfx[i] && !last_gfx[i]) gfx_en[i] <= !gfx_en[i];
            end
        end
    end

    a_soft_rst_pulse : assert property (@(posedge clk_sys) disable iff (rst)
        soft_rst |=> !soft_rst);

endmodule

`default_nettype wire

/* src/board_pkg.sv */
// Board wrapper shared definitions
// Joystick word widths, player count and layer count used by the
// input, control and top level blocks
`default_nettype none

package board_pkg;

    localparam int JOY_BOARD_W = 16;   // Raw joystick word from the board
    localparam int JOY_GAME_W  = 10;   // Joystick word seen by the game
    localparam int DIR_W       = 4;    // Bit 0 right, 1 left, 2 down, 3 up
    localparam int PLAYERS     = 4;
    localparam int GFX_LAYERS  = 4;

    typedef logic [JOY_BOARD_W-1:0] board_joy_t;
    typedef logic [JOY_GAME_W-1:0]  game_joy_t;
    typedef logic [DIR_W-1:0]       dir_t;

endpackage

`default_nettype wire

/* src/color_expand.sv */
// Direct video path
// Widens each colour to 8 bits by bit repetition and registers
// colour, syncs and display enable in one stage
`timescale 1ns/1ps
`default_nettype none

module color_expand #(
    parameter int COLORW = 4
) (
    input  logic              clk_sys,
    input  logic [COLORW-1:0] game_r,
    input  logic [COLORW-1:0] game_g,
    input  logic [COLORW-1:0] game_b,
    input  logic              LHBL,
    input  logic              LVBL,
    input  logic              hs,
    input  logic              vs,
    output logic [7:0]        video_r,
    output logic [7:0]        video_g,
    output logic [7:0]        video_b,
    output logic              video_hs,
    output logic              video_vs,
    output logic              video_de
);

    // Repeat the colour from its MSB until 8 bits are filled
    function automatic logic [7:0] expand8(input logic [COLORW-1:0] c);
        logic [7:0] wide;
        for (int i = 0; i < 8; i++) begin
            wide[7-i] = c[COLORW-1-(i % COLORW)];
        end
        return wide;
    endfunction

    always_ff @(posedge clk_sys) begin
        video_r  <= expand8(game_r);
        video_g  <= expand8(game_g);
        video_b  <= expand8(game_b);
        video_hs <= hs;
        video_vs <= vs;
        video_de <= LHBL & LVBL;                 // Outside both blanks
    end

endmodule

`default_nettype wire

/* src/game_board.sv */
// Arcade board wrapper, input and reset side
// Connects the reset stretcher, joystick mapping, board controls
// and the direct video path
`timescale 1ns/1ps
`default_nettype none

module game_board #(
    parameter int          BUTTONS                = 2,
    parameter int          GAME_INPUTS_ACTIVE_LOW = 1,
    parameter int          COLORW                 = 4,
    parameter int unsigned GAME_RST_LEN           = 255
) (
    input  logic                             clk_sys,
    input  logic                             rst,
    input  logic                             rst_req,
    input  logic                             downloading,
    input  logic                             en_4way,
    input  logic                             rot_control,
    input  board_pkg::board_joy_t            board_joystick1,
    input  board_pkg::board_joy_t            board_joystick2,
    input  board_pkg::board_joy_t            board_joystick3,
    input  board_pkg::board_joy_t            board_joystick4,
    input  logic                             key_reset,
    input  logic                             key_pause,
    input  logic                             key_service,
    input  logic [board_pkg::GFX_LAYERS-1:0] key_gfx,
    input  logic                             osd_pause,
    input  logic [COLORW-1:0]                game_r,
    input  logic [COLORW-1:0]                game_g,
    input  logic [COLORW-1:0]                game_b,
    input  logic                             LHBL,
    input  logic                             LVBL,
    input  logic                             hs,
    input  logic                             vs,
    output logic                             game_rst,
    output logic                             game_rst_n,
    output board_pkg::game_joy_t             game_joystick1,
    output board_pkg::game_joy_t             game_joystick2,
    output board_pkg::game_joy_t             game_joystick3,
    output board_pkg::game_joy_t             game_joystick4,
    output logic [board_pkg::PLAYERS-1:0]    game_coin,
    output logic [board_pkg::PLAYERS-1:0]    game_start,
    output logic                             game_service,
    output logic                             game_pause,
    output logic [board_pkg::GFX_LAYERS-1:0] gfx_en,
    output logic [7:0]                       video_r,
    output logic [7:0]                       video_g,
    output logic [7:0]                       video_b,
    output logic                             video_hs,
    output logic                             video_vs,
    output logic                             video_de
);

    logic joy_pause;    // Players 1 and 2 pause button
    logic soft_rst;     // Keyboard reset pulse

    reset_gen #(.GAME_RST_LEN(GAME_RST_LEN)) u_reset_gen (
        .clk_sys     ( clk_sys     ),
        .rst         ( rst         ),
        .rst_req     ( rst_req     ),
        .downloading ( downloading ),
        .soft_rst    ( soft_rst    ),
        .game_rst    ( game_rst    ),
        .game_rst_n  ( game_rst_n  )
    );

    input_map #(
        .BUTTONS                ( BUTTONS                ),
        .GAME_INPUTS_ACTIVE_LOW ( GAME_INPUTS_ACTIVE_LOW )
    ) u_input_map (
        .clk_sys         ( clk_sys         ),
        .rst             ( rst             ),
        .en_4way         ( en_4way         ),
        .rot_control     ( rot_control     ),
        .board_joystick1 ( board_joystick1 ),
        .board_joystick2 ( board_joystick2 ),
        .board_joystick3 ( board_joystick3 ),
        .board_joystick4 ( board_joystick4 ),
        .key_service     ( key_service     ),
        .game_joystick1  ( game_joystick1  ),
        .game_joystick2  ( game_joystick2  ),
        .game_joystick3  ( game_joystick3  ),
        .game_joystick4  ( game_joystick4  ),
        .game_coin       ( game_coin       ),
        .game_start      ( game_start      ),
        .game_service    ( game_service    ),
        .joy_pause       ( joy_pause       )
    );

    board_ctrl u_board_ctrl (
        .clk_sys     ( clk_sys     ),
        .rst         ( rst         ),
        .downloading ( downloading ),
        .key_reset   ( key_reset   ),
        .key_pause   ( key_pause   ),
        .joy_pause   ( joy_pause   ),
        .osd_pause   ( osd_pause   ),
        .key_gfx     ( key_gfx     ),
        .soft_rst    ( soft_rst    ),
        .game_pause  ( game_pause  ),
        .gfx_en      ( gfx_en      )
    );

    color_expand #(.COLORW(COLORW)) u_color_expand (
        .clk_sys  ( clk_sys  ),
        .game_r   ( game_r   ),
        .game_g   ( game_g   ),
        .game_b   ( game_b   ),
        .LHBL     ( LHBL     ),
        .LVBL     ( LVBL     ),
        .hs       ( hs       ),
        .vs       ( vs       ),
        .video_r  ( video_r  ),
        .video_g  ( video_g  ),
        .video_b  ( video_b  ),
        .video_hs ( video_hs ),
        .video_vs ( video_vs ),
        .video_de ( video_de )
    );

endmodule

`default_nettype wire

/* src/input_map.sv */
// Joystick and button mapping for four players
// Directions go through the 4-way filter, then every word is synced,
// rotated for vertical games and inverted to the game's active level.
// Coin and start are gathered per player from the synced words
`timescale 1ns/1ps
`default_nettype none

module input_map #(
    parameter int BUTTONS                = 2,
    parameter int GAME_INPUTS_ACTIVE_LOW = 1
) (
    input  logic                          clk_sys,
    input  logic                          rst,
    input  logic                          en_4way,
    input  logic                          rot_control,
    input  board_pkg::board_joy_t         board_joystick1,
    input  board_pkg::board_joy_t         board_joystick2,
    input  board_pkg::board_joy_t         board_joystick3,
    input  board_pkg::board_joy_t         board_joystick4,
    input  logic                          key_service,
    output board_pkg::game_joy_t          game_joystick1,
    output board_pkg::game_joy_t          game_joystick2,
    output board_pkg::game_joy_t          game_joystick3,
    output board_pkg::game_joy_t          game_joystick4,
    output logic [board_pkg::PLAYERS-1:0] game_coin,
    output logic [board_pkg::PLAYERS-1:0] game_start,
    output logic                          game_service,
    output logic                          joy_pause
);

    import board_pkg::*;

    localparam int   START_BIT = 6 + BUTTONS - 2;
    localparam int   COIN_BIT  = 7 + BUTTONS - 2;
    localparam int   PAUSE_BIT = 8 + BUTTONS - 2;
    localparam logic INV       = GAME_INPUTS_ACTIVE_LOW != 0;

    dir_t       joy_dir  [PLAYERS];   // Filtered directions
    board_joy_t joy_sync [PLAYERS];

    // Rotation swaps the direction bits, then the whole word is inverted
    function automatic game_joy_t map_joy(input board_joy_t sync_word, input logic rot);
        game_joy_t joy;
        joy = sync_word[JOY_GAME_W-1:0];
        if (rot) begin
            joy[DIR_W-1:0] = {sync_word[0], sync_word[1], sync_word[3], sync_word[2]};
        end
        return joy ^ {JOY_GAME_W{INV}};
    endfunction

    joy_4way u_4way_1p (
        .clk_sys ( clk_sys                    ),
        .rst     ( rst                        ),
        .enable  ( en_4way                    ),
        .joy8way ( board_joystick1[DIR_W-1:0] ),
        .joy4way ( joy_dir[0]                 )
    );

    joy_4way u_4way_2p (
        .clk_sys ( clk_sys                    ),
        .rst     ( rst                        ),
        .enable  ( en_4way                    ),
        .joy8way ( board_joystick2[DIR_W-1:0] ),
        .joy4way ( joy_dir[1]                 )
    );

    joy_4way u_4way_3p (
        .clk_sys ( clk_sys                    ),
        .rst     ( rst                        ),
        .enable  ( en_4way                    ),
        .joy8way ( board_joystick3[DIR_W-1:0] ),
        .joy4way ( joy_dir[2]                 )
    );

    joy_4way u_4way_4p (
        .clk_sys ( clk_sys                    ),
        .rst     ( rst                        ),
        .enable  ( en_4way                    ),
        .joy8way ( board_joystick4[DIR_W-1:0] ),
        .joy4way ( joy_dir[3]                 )
    );

    // Sync stage, filtered directions replace the raw ones
    always_ff @(posedge clk_sys) begin
        joy_sync[0] <= {board_joystick1[JOY_BOARD_W-1:DIR_W], joy_dir[0]};
        joy_sync[1] <= {board_joystick2[JOY_BOARD_W-1:DIR_W], joy_dir[1]};
        joy_sync[2] <= {board_joystick3[JOY_BOARD_W-1:DIR_W], joy_dir[2]};
        joy_sync[3] <= {board_joystick4[JOY_BOARD_W-1:DIR_W], joy_dir[3]};
    end

    always_ff @(posedge clk_sys) begin
        game_joystick1 <= map_joy(joy_sync[0], rot_control);
        game_joystick2 <= map_joy(joy_sync[1], rot_control);
        game_joystick3 <= map_joy(joy_sync[2], rot_control);
        game_joystick4 <= map_joy(joy_sync[3], rot_control);
        for (int p = 0; p < PLAYERS; p++) begin
            game_coin[p]  <= joy_sync[p][COIN_BIT] ^ INV;    // Player 1 in bit 0
            game_start[p] <= joy_sync[p][START_BIT] ^ INV;
        end
    end

    always_ff @(posedge clk_sys) begin
        if (rst) begin
            game_service <= INV;                 // Inactive level
        end else begin
            game_service <= key_service ^ INV;
        end
    end

    // Pause button from either of the first two players
    assign joy_pause = joy_sync[0][PAUSE_BIT] | joy_sync[1][PAUSE_BIT];

endmodule

`default_nettype wire

/* src/joy_4way.sv */
// 4-way joystick filter for one player
// Diagonals are replaced by the last single direction seen
`timescale 1ns/1ps
`default_nettype none

module joy_4way (
    input  logic            clk_sys,
    input  logic            rst,
    input  logic            enable,
    input  board_pkg::dir_t joy8way,
    output board_pkg::dir_t joy4way
);

    import board_pkg::*;

    dir_t last_dir;      // Last accepted single direction
    logic single_dir;

    // Zero or one bit set
    assign single_dir = (joy8way & (joy8way - 1'b1)) == '0;

    always_ff @(posedge clk_sys) begin
        if (rst) begin
            last_dir <= '0;
            joy4way  <= '0;
        end else if (!enable) begin
            joy4way <= joy8way;             // Plain 8-way
        end else if (single_dir) begin
            joy4way  <= joy8way;
            last_dir <= joy8way;
        end else begin
            joy4way <= last_dir;            // Diagonal keeps old direction
        end
    end

    a_single_dir : assert property (@(posedge clk_sys) disable iff (rst)
        $past(enable) |-> $onehot0(joy4way));

endmodule

`default_nettype wire

/* src/reset_gen.sv */
// Game reset stretcher
// Any reset cause restarts an 8-bit counter and game_rst stays high
// until GAME_RST_LEN cycles have passed after the last cause.
// game_rst_n follows through two register stages on release
`timescale 1ns/1ps
`default_nettype none

module reset_gen #(
    parameter int unsigned GAME_RST_LEN = 255
) (
    input  logic clk_sys,
    input  logic rst,
    input  logic rst_req,
    input  logic downloading,
    input  logic soft_rst,
    output logic game_rst,
    output logic game_rst_n
);

    localparam logic [7:0] LEN_LAST = 8'(GAME_RST_LEN);

    logic [7:0] stretch_cnt;
    logic       pre_rst_n;
    logic       rst_cause;

    assign rst_cause = rst | rst_req | downloading | soft_rst;

    always_ff @(posedge clk_sys) begin
        if (rst_cause) begin
            stretch_cnt <= '0;              // Restart on every cause
            game_rst    <= 1'b1;
        end else if (stretch_cnt != LEN_LAST) begin
            stretch_cnt <= stretch_cnt + 8'd1;
            game_rst    <= 1'b1;
        end else begin
            game_rst <= 1'b0;
        end
    end

    // Active low copy, released two cycles late
    always_ff @(posedge clk_sys) begin
        if (game_rst) begin
            pre_rst_n  <= 1'b0;
            game_rst_n <= 1'b0;
        end else begin
            pre_rst_n  <= 1'b1;
            game_rst_n <= pre_rst_n;
        end
    end

    // game_rst_n only high once game_rst has been low for two cycles
    a_rst_n_release : assert property (@(posedge clk_sys) disable iff (rst)
        game_rst_n |-> !$past(game_rst) && !$past(game_rst, 2));

endmodule

`default_nettype wire

/* verilog.f */
src/board_pkg.sv
src/reset_gen.sv
src/joy_4way.sv
src/input_map.sv
src/board_ctrl.sv
src/color_expand.sv
src/game_board.sv
dv/tb_clk_gen.sv
dv/tb_game_board.sv
